// ==== hw/rr_arbiter.sv ====
// ---------------------------------------------------------------------
// Round-robin arbiter with a rotating priority pointer
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [NumPorts-1:0] req_i,
  output logic [NumPorts-1:0] gnt_o,
  input  logic                advance_i
);

  localparam int unsigned PtrWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [PtrWidth-1:0] ptr_q;
  logic [PtrWidth-1:0] win_idx;
  logic [PtrWidth-1:0] next_idx;
  logic                found;

  // First requester at or after the pointer
  always_comb begin
    int unsigned cand;
    gnt_o   = '0;
    win_idx = ptr_q;
    found   = 1'b0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = (ptr_q + i) % NumPorts;
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        win_idx     = PtrWidth'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  assign next_idx = (win_idx == PtrWidth'(NumPorts - 1)) ? '0 : win_idx + 1'b1;

  // Park on a stalled winner so its grant holds until the transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= advance_i ? next_idx : win_idx;
    end
  end

endmodule

// ==== hw/tcdm_bank.sv ====
// ---------------------------------------------------------------------
// TCDM word bank
// Register array with byte-enable writes and a response FIFO
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned RespFifoDepth = 2
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  tcdm_group_pkg::bank_req_t  req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output tcdm_group_pkg::bank_resp_t resp_o,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i
);

  localparam int unsigned NumWords  = 2 ** tcdm_group_pkg::BankAddrWidth;
  localparam int unsigned NumLanes  = tcdm_group_pkg::StrbWidth;
  localparam int unsigned LaneWidth = tcdm_group_pkg::DataWidth / NumLanes;
  localparam int unsigned PtrWidth  = (RespFifoDepth > 1) ? $clog2(RespFifoDepth) : 1;
  localparam int unsigned CntWidth  = $clog2(RespFifoDepth + 1);

  tcdm_group_pkg::data_t      mem_q  [NumWords];
  tcdm_group_pkg::bank_resp_t fifo_q [RespFifoDepth];

  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(RespFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign req_ready_o  = count_q < CntWidth'(RespFifoDepth);
  assign resp_valid_o = count_q != '0;
  assign resp_o       = fifo_q[rd_ptr_q];
  assign push         = req_valid_i & req_ready_o;
  assign pop          = resp_valid_o & resp_ready_i;

  // Old word goes to the FIFO, masked write lands in the same edge
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{ini_addr: req_i.ini_addr, rdata: mem_q[req_i.bank_addr]};
      if (req_i.wen) begin
        for (int unsigned i = 0; i < NumLanes; i++) begin
          if (req_i.be[i]) begin
            mem_q[req_i.bank_addr][i*LaneWidth +: LaneWidth] <=
              req_i.wdata[i*LaneWidth +: LaneWidth];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== hw/tcdm_group.sv ====
// ---------------------------------------------------------------------
// TCDM tile group local interconnect
// Request crossbar, one word bank per tile, response crossbar
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tcdm_group #(
  parameter int unsigned RespFifoDepth = 2
) (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  tcdm_group_pkg::tcdm_req_t  [tcdm_group_pkg::NumTiles-1:0] req_i,
  input  logic                       [tcdm_group_pkg::NumTiles-1:0] req_valid_i,
  output logic                       [tcdm_group_pkg::NumTiles-1:0] req_ready_o,
  output tcdm_group_pkg::tcdm_resp_t [tcdm_group_pkg::NumTiles-1:0] resp_o,
  output logic                       [tcdm_group_pkg::NumTiles-1:0] resp_valid_o,
  input  logic                       [tcdm_group_pkg::NumTiles-1:0] resp_ready_i
);

  localparam int unsigned NumTiles = tcdm_group_pkg::NumTiles;

  tcdm_group_pkg::bank_req_t  [NumTiles-1:0] bank_req;
  logic                       [NumTiles-1:0] bank_req_valid;
  logic                       [NumTiles-1:0] bank_req_ready;
  tcdm_group_pkg::bank_resp_t [NumTiles-1:0] bank_resp;
  logic                       [NumTiles-1:0] bank_resp_valid;
  logic                       [NumTiles-1:0] bank_resp_ready;

  tcdm_req_xbar #(
    .NumPorts(NumTiles)
  ) i_req_xbar (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .bank_req_o      (bank_req),
    .bank_req_valid_o(bank_req_valid),
    .bank_req_ready_i(bank_req_ready)
  );

  for (genvar t = 0; t < NumTiles; t++) begin : gen_banks
    tcdm_bank #(
      .RespFifoDepth(RespFifoDepth)
    ) i_bank (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (bank_req[t]),
      .req_valid_i (bank_req_valid[t]),
      .req_ready_o (bank_req_ready[t]),
      .resp_o      (bank_resp[t]),
      .resp_valid_o(bank_resp_valid[t]),
      .resp_ready_i(bank_resp_ready[t])
    );
  end

  tcdm_resp_xbar #(
    .NumPorts(NumTiles)
  ) i_resp_xbar (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .bank_resp_i      (bank_resp),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ready_o(bank_resp_ready),
    .resp_o           (resp_o),
    .resp_valid_o     (resp_valid_o),
    .resp_ready_i     (resp_ready_i)
  );

endmodule

// ==== hw/tcdm_group_pkg.sv ====
// ---------------------------------------------------------------------
// TCDM tile group shared definitions
// Widths, vector types and request/response structs of the crossbar
// ---------------------------------------------------------------------
package tcdm_group_pkg;

  // One bank per tile
  localparam int unsigned NumTiles      = 4;
  localparam int unsigned TileIdxWidth  = 2;
  localparam int unsigned BankAddrWidth = 8;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned StrbWidth     = 4;

  typedef logic [TileIdxWidth-1:0]               tile_idx_t;
  typedef logic [BankAddrWidth-1:0]              bank_addr_t;
  // Bank index in the low bits, bank word above
  typedef logic [BankAddrWidth+TileIdxWidth-1:0] tcdm_addr_t;
  typedef logic [DataWidth-1:0]                  data_t;
  typedef logic [StrbWidth-1:0]                  strb_t;

  typedef struct packed {
    tcdm_addr_t tgt_addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } tcdm_req_t;

  typedef struct packed {
    bank_addr_t bank_addr;
    tile_idx_t  ini_addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } bank_req_t;

  typedef struct packed {
    tile_idx_t ini_addr;
    data_t     rdata;
  } bank_resp_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

endpackage

// ==== hw/tcdm_req_xbar.sv ====
// ---------------------------------------------------------------------
// TCDM request crossbar
// Bank decode, per-bank arbitration and initiator tagging
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tcdm_req_xbar #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  tcdm_group_pkg::tcdm_req_t [NumPorts-1:0] req_i,
  input  logic                      [NumPorts-1:0] req_valid_i,
  output logic                      [NumPorts-1:0] req_ready_o,
  output tcdm_group_pkg::bank_req_t [NumPorts-1:0] bank_req_o,
  output logic                      [NumPorts-1:0] bank_req_valid_o,
  input  logic                      [NumPorts-1:0] bank_req_ready_i
);

  localparam int unsigned IdxW  = tcdm_group_pkg::TileIdxWidth;
  localparam int unsigned AddrW = tcdm_group_pkg::BankAddrWidth;

  tcdm_group_pkg::tile_idx_t [NumPorts-1:0] bank_sel;
  // Indexed [bank][master]
  logic [NumPorts-1:0][NumPorts-1:0] bank_match;
  logic [NumPorts-1:0][NumPorts-1:0] bank_gnt;

  for (genvar m = 0; m < NumPorts; m++) begin : gen_decode
    assign bank_sel[m] = req_i[m].tgt_addr[IdxW-1:0];
  end

  for (genvar b = 0; b < NumPorts; b++) begin : gen_bank
    tcdm_group_pkg::bank_req_t sel_req;

    for (genvar m = 0; m < NumPorts; m++) begin : gen_match
      assign bank_match[b][m] = req_valid_i[m] &&
                                (bank_sel[m] == tcdm_group_pkg::tile_idx_t'(b));
    end

    rr_arbiter #(
      .NumPorts(NumPorts)
    ) i_arb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (bank_match[b]),
      .gnt_o    (bank_gnt[b]),
      .advance_i(bank_req_valid_o[b] & bank_req_ready_i[b])
    );

    always_comb begin
      sel_req = '0;
      for (int unsigned m = 0; m < NumPorts; m++) begin
        if (bank_gnt[b][m]) begin
          sel_req.bank_addr = req_i[m].tgt_addr[IdxW +: AddrW];
          sel_req.ini_addr  = tcdm_group_pkg::tile_idx_t'(m);
          sel_req.wen       = req_i[m].wen;
          sel_req.wdata     = req_i[m].wdata;
          sel_req.be        = req_i[m].be;
        end
      end
    end

    assign bank_req_valid_o[b] = |bank_match[b];
    assign bank_req_o[b]       = sel_req;
  end

  // Winner sees ready once its bank can accept
  always_comb begin
    req_ready_o = '0;
    for (int unsigned b = 0; b < NumPorts; b++) begin
      for (int unsigned m = 0; m < NumPorts; m++) begin
        if (bank_gnt[b][m] && bank_req_ready_i[b]) begin
          req_ready_o[m] = 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/tcdm_resp_xbar.sv ====
// ---------------------------------------------------------------------
// TCDM response crossbar
// Routes bank FIFO heads back to the initiator named in their tag
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tcdm_resp_xbar #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  tcdm_group_pkg::bank_resp_t [NumPorts-1:0] bank_resp_i,
  input  logic                       [NumPorts-1:0] bank_resp_valid_i,
  output logic                       [NumPorts-1:0] bank_resp_ready_o,
  output tcdm_group_pkg::tcdm_resp_t [NumPorts-1:0] resp_o,
  output logic                       [NumPorts-1:0] resp_valid_o,
  input  logic                       [NumPorts-1:0] resp_ready_i
);

  // Indexed [master][bank]
  logic [NumPorts-1:0][NumPorts-1:0] mst_match;
  logic [NumPorts-1:0][NumPorts-1:0] mst_gnt;

  for (genvar m = 0; m < NumPorts; m++) begin : gen_master
    tcdm_group_pkg::tcdm_resp_t sel_resp;

    for (genvar b = 0; b < NumPorts; b++) begin : gen_match
      assign mst_match[m][b] = bank_resp_valid_i[b] &&
        (bank_resp_i[b].ini_addr == tcdm_group_pkg::tile_idx_t'(m));
    end

    rr_arbiter #(
      .NumPorts(NumPorts)
    ) i_arb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (mst_match[m]),
      .gnt_o    (mst_gnt[m]),
      .advance_i(resp_valid_o[m] & resp_ready_i[m])
    );

    always_comb begin
      sel_resp = '0;
      for (int unsigned b = 0; b < NumPorts; b++) begin
        if (mst_gnt[m][b]) begin
          sel_resp.rdata = bank_resp_i[b].rdata;
        end
      end
    end

    assign resp_valid_o[m] = |mst_match[m];
    assign resp_o[m]       = sel_resp;
  end

  // Pop the granted head when its master takes it
  always_comb begin
    bank_resp_ready_o = '0;
    for (int unsigned m = 0; m < NumPorts; m++) begin
      for (int unsigned b = 0; b < NumPorts; b++) begin
        if (mst_gnt[m][b] && resp_ready_i[m]) begin
          bank_resp_ready_o[b] = 1'b1;
        end
      end
    end
  end

endmodule

// ==== tcdm_group.f ====
hw/tcdm_group_pkg.sv
hw/rr_arbiter.sv
hw/tcdm_req_xbar.sv
hw/tcdm_bank.sv
hw/tcdm_resp_xbar.sv
hw/tcdm_group.sv
verif/tcdm_group_assertions.sv
verif/tcdm_group_tb.sv

// ==== verif/tcdm_group_assertions.sv ====
// ---------------------------------------------------------------------
// TCDM tile group handshake assertions, bound to the top level
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tcdm_group_assertions (
  input logic                                                      clk_i,
  input logic                                                      reset_i,
  input tcdm_group_pkg::tcdm_req_t  [tcdm_group_pkg::NumTiles-1:0] req_i,
  input logic                       [tcdm_group_pkg::NumTiles-1:0] req_valid_i,
  input logic                       [tcdm_group_pkg::NumTiles-1:0] req_ready_o,
  input tcdm_group_pkg::tcdm_resp_t [tcdm_group_pkg::NumTiles-1:0] resp_o,
  input logic                       [tcdm_group_pkg::NumTiles-1:0] resp_valid_o,
  input logic                       [tcdm_group_pkg::NumTiles-1:0] resp_ready_i
);

  // Failed assertions so far
  int unsigned failures = 0;

  for (genvar m = 0; m < tcdm_group_pkg::NumTiles; m++) begin : gen_port
    resp_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
      resp_valid_o[m] && !resp_ready_i[m] |=> resp_valid_o[m] && $stable(resp_o[m]))
      else begin
        failures++;
        $error("response on port %0d changed while stalled", m);
      end

    req_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
      req_valid_i[m] && !req_ready_o[m] |=> req_valid_i[m] && $stable(req_i[m]))
      else begin
        failures++;
        $error("request on port %0d changed before acceptance", m);
      end
  end

  // No response may be pending right after reset
  reset_clear_a : assert property (@(posedge clk_i) $fell(reset_i) |-> resp_valid_o == '0)
    else begin
      failures++;
      $error("resp_valid_o high in the first cycle after reset");
    end

endmodule

bind tcdm_group tcdm_group_assertions i_assertions (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_i       (req_i),
  .req_valid_i (req_valid_i),
  .req_ready_o (req_ready_o),
  .resp_o      (resp_o),
  .resp_valid_o(resp_valid_o),
  .resp_ready_i(resp_ready_i)
);

// ==== verif/tcdm_group_tb.sv ====
// ---------------------------------------------------------------------
// TCDM tile group testbench
// Directed and random traffic against a word-addressed reference model
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tcdm_group_tb;

  localparam int unsigned RespFifoDepth = 2;
  localparam int unsigned NumTiles      = tcdm_group_pkg::NumTiles;
  localparam int unsigned TimeoutCycles = 20000;

  logic                                      clk_i;
  logic                                      reset_i;
  tcdm_group_pkg::tcdm_req_t  [NumTiles-1:0] req_i;
  logic                       [NumTiles-1:0] req_valid_i;
  logic                       [NumTiles-1:0] req_ready_o;
  tcdm_group_pkg::tcdm_resp_t [NumTiles-1:0] resp_o;
  logic                       [NumTiles-1:0] resp_valid_o;
  logic                       [NumTiles-1:0] resp_ready_i;

  tcdm_group_pkg::data_t model [1024];
  logic [31:0] seed   = 32'd20733;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;

  tcdm_group #(
    .RespFifoDepth(RespFifoDepth)
  ) UUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .resp_o      (resp_o),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, a request or response never completed", cycles);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic tcdm_group_pkg::data_t fill_word(input tcdm_group_pkg::tcdm_addr_t addr);
    return {6'h2b, addr, 6'h15, ~addr};
  endfunction

  function automatic tcdm_group_pkg::data_t merge_bytes(input tcdm_group_pkg::data_t old_word,
                                                        input tcdm_group_pkg::data_t new_word,
                                                        input tcdm_group_pkg::strb_t be);
    tcdm_group_pkg::data_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    $display("%-14s done, %0d errors", name, errors - err0);
  endtask

  // One access on port m with the model updated when its acceptance is seen
  task automatic run_access(input int m, input tcdm_group_pkg::tcdm_addr_t addr,
                            input logic wen, input tcdm_group_pkg::data_t wdata,
                            input tcdm_group_pkg::strb_t be, input bit check_en);
    tcdm_group_pkg::tcdm_req_t req;
    tcdm_group_pkg::data_t     expected;
    req.tgt_addr = addr;
    req.wen      = wen;
    req.wdata    = wdata;
    req.be       = be;
    @(negedge clk_i);
    req_i[m]       = req;
    req_valid_i[m] = 1'b1;
    #1;
    // No response is due before this request is accepted
    check_value($sformatf("resp_valid_o[%0d]", m), 1'b0, resp_valid_o[m]);
    while (!req_ready_o[m]) begin
      @(negedge clk_i);
      #1;
    end
    expected = model[addr];
    if (wen) begin
      model[addr] = merge_bytes(model[addr], wdata, be);
    end
    @(negedge clk_i);
    req_valid_i[m] = 1'b0;
    #1;
    while (!resp_valid_o[m]) begin
      @(negedge clk_i);
      #1;
    end
    if (check_en) begin
      check_value($sformatf("resp_o[%0d].rdata", m), expected, resp_o[m].rdata);
    end
    @(posedge clk_i);
  endtask

  // Each port fills its own bank, so the four run without conflicts
  task automatic preload_port(input int m);
    tcdm_group_pkg::tcdm_addr_t addr;
    for (int w = 0; w < 256; w++) begin
      addr = {8'(w), 2'(m)};
      run_access(m, addr, 1'b1, fill_word(addr), 4'hF, 1'b0);
    end
  endtask

  task automatic random_port(input int m, input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = next_random();
      run_access(m, r[25:16], r[3], next_random(), r[7:4], 1'b1);
    end
  endtask

  task automatic write_then_read();
    int                         err0;
    tcdm_group_pkg::tcdm_addr_t addr;
    err0 = errors;
    for (int m = 0; m < NumTiles; m++) begin
      addr = tcdm_group_pkg::tcdm_addr_t'(m * 37 + 5);
      run_access(m, addr, 1'b1, next_random(), 4'hF, 1'b1);
      run_access(m, addr, 1'b0, '0, '0, 1'b1);
    end
    finish_test("write_read", err0);
  endtask

  task automatic partial_writes();
    int                    err0;
    tcdm_group_pkg::strb_t patterns [6] = '{4'b0001, 4'b0110, 4'b1000,
                                             4'b1010, 4'b0000, 4'b1101};
    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      run_access(1, {8'd77, 2'd2}, 1'b1, next_random(), patterns[i], 1'b1);
      run_access(1, {8'd77, 2'd2}, 1'b0, '0, '0, 1'b1);
    end
    finish_test("byte_enables", err0);
  endtask

  task automatic bank_conflict();
    int err0;
    err0 = errors;
    fork
      run_access(0, {8'd40, 2'd3}, 1'b0, '0, '0, 1'b1);
      run_access(1, {8'd41, 2'd3}, 1'b1, next_random(), 4'hF, 1'b1);
      run_access(2, {8'd42, 2'd3}, 1'b0, '0, '0, 1'b1);
      run_access(3, {8'd43, 2'd3}, 1'b1, next_random(), 4'hF, 1'b1);
    join
    finish_test("bank_conflict", err0);
  endtask

  task automatic back_pressure();
    int                         err0;
    int                         accepted;
    int                         total;
    int                         got;
    bit                         blocked;
    bit                         taken;
    tcdm_group_pkg::tcdm_addr_t addr;
    tcdm_group_pkg::data_t      exp_q [$];
    err0     = errors;
    addr     = {8'd200, 2'd1};
    accepted = 0;
    blocked  = 1'b0;
    @(negedge clk_i);
    resp_ready_i[0] = 1'b0;
    while (!blocked && accepted < 8) begin
      req_i[0]       = '{tgt_addr: addr, wen: 1'b1, wdata: next_random(), be: 4'hF};
      req_valid_i[0] = 1'b1;
      #1;
      if (req_ready_o[0]) begin
        exp_q.push_back(model[addr]);
        model[addr] = req_i[0].wdata;
        accepted++;
        @(negedge clk_i);
      end else begin
        blocked = 1'b1;
      end
    end
    check_value("req_ready_o[0] acceptances", RespFifoDepth, accepted);
    total = blocked ? accepted + 1 : accepted;
    if (!blocked) begin
      req_valid_i[0] = 1'b0;
    end
    repeat (3) begin
      @(negedge clk_i);
      #1;
      check_value("req_ready_o[0]", 1'b0, req_ready_o[0]);
    end
    @(negedge clk_i);
    resp_ready_i[0] = 1'b1;
    got = 0;
    while (got < total) begin
      #1;
      taken = req_valid_i[0] && req_ready_o[0];
      if (taken) begin
        exp_q.push_back(model[addr]);
        model[addr] = req_i[0].wdata;
      end
      if (resp_valid_o[0]) begin
        check_value("resp_o[0].rdata", exp_q.pop_front(), resp_o[0].rdata);
        got++;
      end
      @(negedge clk_i);
      if (taken) begin
        req_valid_i[0] = 1'b0;
      end
    end
    finish_test("back_pressure", err0);
  endtask

  task automatic random_traffic();
    int err0;
    err0 = errors;
    fork
      random_port(0, 50);
      random_port(1, 50);
      random_port(2, 50);
      random_port(3, 50);
    join
    finish_test("random", err0);
  endtask

  initial begin
    reset_i      = 1'b1;
    req_i        = '0;
    req_valid_i  = '0;
    resp_ready_i = '1;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    fork
      preload_port(0);
      preload_port(1);
      preload_port(2);
      preload_port(3);
    join
    $display("preload       done, all 1024 words written");
    write_then_read();
    partial_writes();
    bank_conflict();
    back_pressure();
    random_traffic();
    $display("checks %0d, errors %0d, assertion failures %0d, cycles %0d",
             checks, errors, UUT.i_assertions.failures, cycles);
    if (errors == 0 && UUT.i_assertions.failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
